//--- MidiCtrlPkg.sv
// Shared bus, CSR and switch types, block map and CSR offsets
// Address field helpers for the register bus
package MidiCtrlPkg;

	// ------------------------------
	// Bus and board types
	// ------------------------------
	typedef logic [31:0] usiData_t;
	typedef logic [15:0] usiAdrs_t;
	typedef logic [2:0]  blockId_t;
	typedef logic [7:0]  csrAdrs_t;
	// Push switches, 1 = pressed
	typedef logic [6:0]  pushSw_t;
	typedef logic [1:0]  dipSw_t;
	typedef logic [3:0]  led_t;

	// ------------------------------
	// Block map
	// ------------------------------
	// Blocks 2 to 7 unpopulated
	localparam blockId_t lpGpioBlockId  = 3'd0;
	localparam blockId_t lpTimerBlockId = 3'd1;

	// GPIO CSR offsets
	localparam csrAdrs_t lpGpioLedCsr   = 8'h00;
	localparam csrAdrs_t lpGpioAltCsr   = 8'h01;
	localparam csrAdrs_t lpGpioLevelCsr = 8'h02;
	localparam csrAdrs_t lpGpioEdgeCsr  = 8'h03;
	localparam csrAdrs_t lpGpioLongCsr  = 8'h04;

	// Timer CSR offsets
	localparam csrAdrs_t lpTimerCtrlCsr  = 8'h00;
	localparam csrAdrs_t lpTimerCountCsr = 8'h01;
	localparam csrAdrs_t lpTimerCmpCsr   = 8'h02;
	localparam csrAdrs_t lpTimerStatCsr  = 8'h03;

	// Block number lives in the top three address bits
	function automatic blockId_t usiBlock(input usiAdrs_t adrs);
		return adrs[15:13];
	endfunction

	// CSR offset in the low byte, bits 12..8 unused
	function automatic csrAdrs_t usiCsr(input usiAdrs_t adrs);
		return adrs[7:0];
	endfunction

endpackage

//--- SwitchConditioner.sv
// Push switch synchronizer, debouncer, press pulse and long-press pulse
`timescale 1ns/1ps

module SwitchConditioner
	import MidiCtrlPkg::*;
#(
	parameter int unsigned pDebounceCycles = 16,
	parameter int unsigned pLongCycles     = 1024
)
(
	input  logic    iMCLK,
	input  logic    qnARST,
	input  pushSw_t rawSw,
	output pushSw_t swLevel,
	output pushSw_t swPress,
	output pushSw_t swLong
);

	localparam int lpSwNum = $bits(pushSw_t);
	localparam int lpDbW   = $clog2(pDebounceCycles + 1);
	localparam int lpHoldW = $clog2(pLongCycles + 1);
	localparam logic [lpDbW-1:0]   lpDbLast   = lpDbW'(pDebounceCycles - 1);
	localparam logic [lpHoldW-1:0] lpHoldLast = lpHoldW'(pLongCycles - 1);

	pushSw_t            syncA;
	pushSw_t            syncB;
	pushSw_t            longDone;
	logic [lpDbW-1:0]   dbCnt   [lpSwNum];
	logic [lpHoldW-1:0] holdCnt [lpSwNum];

	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			syncA    <= '0;
			syncB    <= '0;
			swLevel  <= '0;
			swPress  <= '0;
			swLong   <= '0;
			longDone <= '0;
			for (int i = 0; i < lpSwNum; i++)
			begin
				dbCnt[i]   <= '0;
				holdCnt[i] <= '0;
			end
		end
		else
		begin
			// Two-flop sync
			syncA <= rawSw;
			syncB <= syncA;
			for (int i = 0; i < lpSwNum; i++)
			begin
				// Level flips after a full run of differing samples
				swPress[i] <= 1'b0;
				if (syncB[i] != swLevel[i])
				begin
					if (dbCnt[i] == lpDbLast)
					begin
						swLevel[i] <= syncB[i];
						swPress[i] <= syncB[i];
						dbCnt[i]   <= '0;
					end
					else
						dbCnt[i] <= dbCnt[i] + 1'b1;
				end
				else
					dbCnt[i] <= '0;
				// Hold timer, one long pulse per press
				swLong[i] <= 1'b0;
				if (!swLevel[i])
				begin
					holdCnt[i]  <= '0;
					longDone[i] <= 1'b0;
				end
				else if (!longDone[i])
				begin
					if (holdCnt[i] == lpHoldLast)
					begin
						swLong[i]   <= 1'b1;
						longDone[i] <= 1'b1;
					end
					else
						holdCnt[i] <= holdCnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

//--- GpioBlock.sv
// GPIO register block: LED and alternate-enable CSRs, sticky switch flags,
// heartbeat divider and per-LED source select
`timescale 1ns/1ps

module GpioBlock
	import MidiCtrlPkg::*;
#(
	parameter int unsigned pDebounceCycles = 16,
	parameter int unsigned pLongCycles     = 1024,
	parameter int unsigned pHeartbeatDiv   = 1048576
)
(
	input  logic     iMCLK,
	input  logic     qnARST,
	// Bus side
	input  logic     gpioSel,
	input  logic     csrWrite,
	input  logic     csrRead,
	input  csrAdrs_t csrAdrs,
	input  usiData_t csrWdata,
	output usiData_t gpioRdata,
	// Board and timer inputs
	input  pushSw_t  pushSw,
	input  dipSw_t   dipSw,
	input  logic     timerMatch,
	output led_t     led
);

	localparam int lpHbW = $clog2(pHeartbeatDiv + 1);
	localparam logic [lpHbW-1:0] lpHbLast = lpHbW'(pHeartbeatDiv - 1);

	logic             csrWe;
	led_t             ledReg;
	led_t             altEn;
	led_t             altSrc;
	pushSw_t          edgeFlag;
	pushSw_t          longFlag;
	pushSw_t          swLevel;
	pushSw_t          swPress;
	pushSw_t          swLong;
	dipSw_t           dipSync;
	logic [lpHbW-1:0] hbCnt;
	logic             heartbeat;

	SwitchConditioner #(
		.pDebounceCycles(pDebounceCycles),
		.pLongCycles(pLongCycles)
	) SwitchConditioner (
		.iMCLK(iMCLK),
		.qnARST(qnARST),
		.rawSw(pushSw),
		.swLevel(swLevel),
		.swPress(swPress),
		.swLong(swLong)
	);

	assign csrWe = gpioSel && csrWrite;

	// ------------------------------
	// CSR write side
	// ------------------------------
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			ledReg   <= '0;
			altEn    <= '0;
			edgeFlag <= '0;
			longFlag <= '0;
			dipSync  <= '0;
		end
		else
		begin
			dipSync <= dipSw;
			if (csrWe && (csrAdrs == lpGpioLedCsr))
				ledReg <= csrWdata[$bits(led_t)-1:0];
			if (csrWe && (csrAdrs == lpGpioAltCsr))
				altEn <= csrWdata[$bits(led_t)-1:0];
			// W1C, a new pulse beats the clear
			if (csrWe && (csrAdrs == lpGpioEdgeCsr))
				edgeFlag <= swPress | (edgeFlag & ~csrWdata[$bits(pushSw_t)-1:0]);
			else
				edgeFlag <= swPress | edgeFlag;
			if (csrWe && (csrAdrs == lpGpioLongCsr))
				longFlag <= swLong | (longFlag & ~csrWdata[$bits(pushSw_t)-1:0]);
			else
				longFlag <= swLong | longFlag;
		end
	end

	// Read data held until the bus picks it up
	always_ff @(posedge iMCLK)
	begin
		if (gpioSel && csrRead)
		begin
			case (csrAdrs)
				lpGpioLedCsr:   gpioRdata <= usiData_t'(ledReg);
				lpGpioAltCsr:   gpioRdata <= usiData_t'(altEn);
				lpGpioLevelCsr: gpioRdata <= usiData_t'({dipSync, 1'b0, swLevel});
				lpGpioEdgeCsr:  gpioRdata <= usiData_t'(edgeFlag);
				lpGpioLongCsr:  gpioRdata <= usiData_t'(longFlag);
				default:        gpioRdata <= '0;
			endcase
		end
	end

	// ------------------------------
	// Heartbeat
	// ------------------------------
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			hbCnt     <= '0;
			heartbeat <= 1'b0;
		end
		else if (hbCnt == lpHbLast)
		begin
			hbCnt     <= '0;
			heartbeat <= ~heartbeat;
		end
		else
			hbCnt <= hbCnt + 1'b1;
	end

	// Alternate sources, LED 3 down to LED 0
	assign altSrc = {dipSync[0], |swLevel, timerMatch, heartbeat};
	assign led    = (altEn & altSrc) | (~altEn & ledReg);

endmodule

//--- SysTimerBlock.sv
// System tick timer block: free-running counter, compare register
// and sticky match flag behind the register bus
`timescale 1ns/1ps

module SysTimerBlock
	import MidiCtrlPkg::*;
(
	input  logic     iMCLK,
	input  logic     qnARST,
	// Bus side
	input  logic     timerSel,
	input  logic     csrWrite,
	input  logic     csrRead,
	input  csrAdrs_t csrAdrs,
	input  usiData_t csrWdata,
	output usiData_t timerRdata,
	// Sticky match, also drives an LED source
	output logic     timerMatch
);

	logic     csrWe;
	logic     timerEn;
	usiData_t tickCnt;
	usiData_t cmpReg;
	logic     matchHit;

	assign csrWe    = timerSel && csrWrite;
	// Compare only counts while running
	assign matchHit = timerEn && (tickCnt == cmpReg);

	// ------------------------------
	// Control, counter, compare
	// ------------------------------
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			timerEn    <= 1'b0;
			tickCnt    <= '0;
			cmpReg     <= '0;
			timerMatch <= 1'b0;
		end
		else
		begin
			if (csrWe && (csrAdrs == lpTimerCtrlCsr))
				timerEn <= csrWdata[0];
			// Bus load takes priority over counting
			if (csrWe && (csrAdrs == lpTimerCountCsr))
				tickCnt <= csrWdata;
			else if (timerEn)
				tickCnt <= tickCnt + 1'b1;
			if (csrWe && (csrAdrs == lpTimerCmpCsr))
				cmpReg <= csrWdata;
			// W1C status, set wins
			if (csrWe && (csrAdrs == lpTimerStatCsr))
				timerMatch <= matchHit | (timerMatch & ~csrWdata[0]);
			else
				timerMatch <= matchHit | timerMatch;
		end
	end

	// Read capture on strobe
	always_ff @(posedge iMCLK)
	begin
		if (timerSel && csrRead)
		begin
			case (csrAdrs)
				lpTimerCtrlCsr:  timerRdata <= usiData_t'(timerEn);
				lpTimerCountCsr: timerRdata <= tickCnt;
				lpTimerCmpCsr:   timerRdata <= cmpReg;
				lpTimerStatCsr:  timerRdata <= usiData_t'(timerMatch);
				default:         timerRdata <= '0;
			endcase
		end
	end

endmodule

//--- UsiBus.sv
// Register bus master side: request strobe stage, block decode,
// read data select and response queue with credit back-pressure
`timescale 1ns/1ps

module UsiBus
	import MidiCtrlPkg::*;
#(
	parameter int unsigned pRspDepth = 4
)
(
	input  logic     iMCLK,
	input  logic     qnARST,
	// Request channel
	input  logic     reqValid,
	input  logic     reqWrite,
	input  usiAdrs_t reqAdrs,
	input  usiData_t reqData,
	output logic     reqReady,
	// Response channel
	output logic     rspValid,
	output usiData_t rspData,
	input  logic     rspReady,
	// Slave side
	output logic     gpioSel,
	output logic     timerSel,
	output logic     csrWrite,
	output logic     csrRead,
	output csrAdrs_t csrAdrs,
	output usiData_t csrWdata,
	input  usiData_t gpioRdata,
	input  usiData_t timerRdata
);

	localparam int lpPtrW = (pRspDepth > 1) ? $clog2(pRspDepth) : 1;
	localparam int lpCntW = $clog2(pRspDepth + 1);
	localparam logic [lpPtrW-1:0] lpLastPtr   = lpPtrW'(pRspDepth - 1);
	localparam logic [lpCntW-1:0] lpCreditMax = lpCntW'(pRspDepth);

	logic              reqAccept;
	blockId_t          strbBlock;
	logic              rdPend;
	blockId_t          rdBlock;
	usiData_t          rdMux;
	logic              rspPop;
	logic [lpCntW-1:0] credits;
	logic [lpCntW-1:0] qCount;
	logic [lpPtrW-1:0] wrPtr;
	logic [lpPtrW-1:0] rdPtr;
	usiData_t          rspMem [pRspDepth];

	// Pointer wrap for any depth
	function automatic logic [lpPtrW-1:0] nextPtr(input logic [lpPtrW-1:0] ptr);
		return (ptr == lpLastPtr) ? '0 : ptr + 1'b1;
	endfunction

	// Credits cover queued data plus reads in flight
	assign reqReady  = (credits < lpCreditMax);
	assign reqAccept = reqValid && reqReady;
	assign rspValid  = (qCount != '0);
	assign rspData   = rspMem[rdPtr];
	assign rspPop    = rspValid && rspReady;

	// ------------------------------
	// Strobe stage
	// ------------------------------
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			gpioSel  <= 1'b0;
			timerSel <= 1'b0;
			csrWrite <= 1'b0;
			csrRead  <= 1'b0;
		end
		else
		begin
			// One select per request, none for empty block slots
			gpioSel  <= reqAccept && (usiBlock(reqAdrs) == lpGpioBlockId);
			timerSel <= reqAccept && (usiBlock(reqAdrs) == lpTimerBlockId);
			csrWrite <= reqAccept && reqWrite;
			csrRead  <= reqAccept && !reqWrite;
		end
	end

	// Request payload
	always_ff @(posedge iMCLK)
	begin
		if (reqAccept)
		begin
			csrAdrs   <= usiCsr(reqAdrs);
			csrWdata  <= reqData;
			strbBlock <= usiBlock(reqAdrs);
		end
	end

	// ------------------------------
	// Read return stage
	// ------------------------------
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
			rdPend <= 1'b0;
		else
			rdPend <= csrRead;
	end

	always_ff @(posedge iMCLK)
	begin
		rdBlock <= strbBlock;
	end

	// Blocks hold their read data one cycle after the strobe
	always_comb
	begin
		case (rdBlock)
			lpGpioBlockId:  rdMux = gpioRdata;
			lpTimerBlockId: rdMux = timerRdata;
			default:        rdMux = '0;
		endcase
	end

	// ------------------------------
	// Response queue
	// ------------------------------
	always_ff @(posedge iMCLK or negedge qnARST)
	begin
		if (!qnARST)
		begin
			credits <= '0;
			qCount  <= '0;
			wrPtr   <= '0;
			rdPtr   <= '0;
		end
		else
		begin
			case ({reqAccept && !reqWrite, rspPop})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
			case ({rdPend, rspPop})
				2'b10:   qCount <= qCount + 1'b1;
				2'b01:   qCount <= qCount - 1'b1;
				default: qCount <= qCount;
			endcase
			if (rdPend)
				wrPtr <= nextPtr(wrPtr);
			if (rspPop)
				rdPtr <= nextPtr(rdPtr);
		end
	end

	// Queue storage, never full on push thanks to credits
	always_ff @(posedge iMCLK)
	begin
		if (rdPend)
			rspMem[wrPtr] <= rdMux;
	end

endmodule

//--- MidiCtrlTop.sv
// Control plane top: register bus plus GPIO and system timer blocks
`timescale 1ns/1ps

module MidiCtrlTop
	import MidiCtrlPkg::*;
#(
	parameter int unsigned pRspDepth       = 4,
	parameter int unsigned pDebounceCycles = 16,
	parameter int unsigned pLongCycles     = 1024,
	parameter int unsigned pHeartbeatDiv   = 1048576
)
(
	input  logic     iMCLK,
	input  logic     qnARST,
	// Request channel
	input  logic     reqValid,
	input  logic     reqWrite,
	input  usiAdrs_t reqAdrs,
	input  usiData_t reqData,
	output logic     reqReady,
	// Response channel
	output logic     rspValid,
	output usiData_t rspData,
	input  logic     rspReady,
	// Board I/O
	input  pushSw_t  pushSw,
	input  dipSw_t   dipSw,
	output led_t     led
);

	// ------------------------------
	// Slave-side bus wires
	// ------------------------------
	logic     gpioSel;
	logic     timerSel;
	logic     csrWrite;
	logic     csrRead;
	csrAdrs_t csrAdrs;
	usiData_t csrWdata;
	usiData_t gpioRdata;
	usiData_t timerRdata;
	// Timer flag into LED 1 source
	logic     timerMatch;

	UsiBus #(
		.pRspDepth(pRspDepth)
	) UsiBus (
		.iMCLK(iMCLK),         .qnARST(qnARST),
		.reqValid(reqValid),   .reqWrite(reqWrite),
		.reqAdrs(reqAdrs),     .reqData(reqData),     .reqReady(reqReady),
		.rspValid(rspValid),   .rspData(rspData),     .rspReady(rspReady),
		.gpioSel(gpioSel),     .timerSel(timerSel),
		.csrWrite(csrWrite),   .csrRead(csrRead),
		.csrAdrs(csrAdrs),     .csrWdata(csrWdata),
		.gpioRdata(gpioRdata), .timerRdata(timerRdata)
	);

	GpioBlock #(
		.pDebounceCycles(pDebounceCycles),
		.pLongCycles(pLongCycles),
		.pHeartbeatDiv(pHeartbeatDiv)
	) GpioBlock (
		.iMCLK(iMCLK),         .qnARST(qnARST),
		.gpioSel(gpioSel),     .csrWrite(csrWrite),   .csrRead(csrRead),
		.csrAdrs(csrAdrs),     .csrWdata(csrWdata),   .gpioRdata(gpioRdata),
		.pushSw(pushSw),       .dipSw(dipSw),         .timerMatch(timerMatch),
		.led(led)
	);

	SysTimerBlock SysTimerBlock (
		.iMCLK(iMCLK),         .qnARST(qnARST),
		.timerSel(timerSel),   .csrWrite(csrWrite),   .csrRead(csrRead),
		.csrAdrs(csrAdrs),     .csrWdata(csrWdata),
		.timerRdata(timerRdata),
		.timerMatch(timerMatch)
	);

endmodule

//--- MidiCtrlTb.sv
// Testbench for the MIDI control plane: random bus traffic from a fixed seed,
// register model, switch and LED stimulus, compare tasks and timeout
`timescale 1ns/1ps

module MidiCtrlTb
	import MidiCtrlPkg::*;
();

	localparam int lpRspDepth   = 4;
	localparam int lpDebounce   = 4;
	localparam int lpLong       = 64;
	localparam int lpHbDiv      = 32;
	// Far above the length of all tests together
	localparam int lpMaxCycles  = 20000;

	logic     iMCLK;
	logic     qnARST;
	logic     reqValid;
	logic     reqWrite;
	usiAdrs_t reqAdrs;
	usiData_t reqData;
	logic     reqReady;
	logic     rspValid;
	usiData_t rspData;
	logic     rspReady;
	pushSw_t  pushSw;
	dipSw_t   dipSw;
	led_t     led;

	integer   seed;
	int       cycleCnt = 0;
	logic     stallEn;
	// Pending reads in request order, capture entries keep raw data
	usiData_t expQ [$];
	bit       capQ [$];
	usiData_t capVal [$];

	// Register model
	led_t     mLed;
	led_t     mAlt;
	pushSw_t  mLevel;
	pushSw_t  mEdge;
	pushSw_t  mLong;
	dipSw_t   mDip;
	logic     mTimerEn;
	logic     mMatch;
	usiData_t mCmp;
	usiData_t mCount;

	MidiCtrlTop #(
		.pRspDepth(lpRspDepth),
		.pDebounceCycles(lpDebounce),
		.pLongCycles(lpLong),
		.pHeartbeatDiv(lpHbDiv)
	) UUT (
		.iMCLK(iMCLK),       .qnARST(qnARST),
		.reqValid(reqValid), .reqWrite(reqWrite),
		.reqAdrs(reqAdrs),   .reqData(reqData),   .reqReady(reqReady),
		.rspValid(rspValid), .rspData(rspData),   .rspReady(rspReady),
		.pushSw(pushSw),     .dipSw(dipSw),       .led(led)
	);

	always #4 iMCLK = ~iMCLK;

	// ------------------------------
	// Error handling and timeout
	// ------------------------------
	task automatic stopOnError();
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkData(input usiData_t got, input usiData_t exp, input string what);
		if (got !== exp)
		begin
			$display("[FAIL] %0t: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
			stopOnError();
		end
	endtask

	task automatic checkLed(input led_t got, input led_t exp, input string what);
		if (got !== exp)
		begin
			$display("[FAIL] %0t: %s, got %b, expected %b", $time, what, got, exp);
			stopOnError();
		end
	endtask

	always @(posedge iMCLK)
	begin
		cycleCnt = cycleCnt + 1;
		if (cycleCnt >= lpMaxCycles)
		begin
			$display("Timeout: the run did not finish within %0d clock cycles", lpMaxCycles);
			stopOnError();
		end
	end

	// ------------------------------
	// Model
	// ------------------------------
	function automatic usiAdrs_t csrAddress(input blockId_t blk, input csrAdrs_t off);
		return {blk, 5'b0, off};
	endfunction

	// Block in bits 15..13, offset in 7..0, middle bits ignored
	function automatic usiData_t predictRead(input usiAdrs_t adrs);
		blockId_t blk;
		csrAdrs_t off;
		usiData_t val;
		blk = adrs[15:13];
		off = adrs[7:0];
		val = '0;
		if (blk == 3'd0)
		begin
			case (off)
				8'h00:   val = usiData_t'(mLed);
				8'h01:   val = usiData_t'(mAlt);
				8'h02:   val = {22'b0, mDip, 1'b0, mLevel};
				8'h03:   val = usiData_t'(mEdge);
				8'h04:   val = usiData_t'(mLong);
				default: val = '0;
			endcase
		end
		else if (blk == 3'd1)
		begin
			case (off)
				8'h00:   val = usiData_t'(mTimerEn);
				// Only meaningful while the timer is stopped
				8'h01:   val = mCount;
				8'h02:   val = mCmp;
				8'h03:   val = usiData_t'(mMatch);
				default: val = '0;
			endcase
		end
		return val;
	endfunction

	function automatic void modelWrite(input usiAdrs_t adrs, input usiData_t data);
		if (adrs[15:13] == 3'd0)
		begin
			case (adrs[7:0])
				8'h00: mLed = data[3:0];
				8'h01: mAlt = data[3:0];
				8'h03: mEdge = mEdge & ~data[6:0];
				8'h04: mLong = mLong & ~data[6:0];
				default: ;
			endcase
		end
		else if (adrs[15:13] == 3'd1)
		begin
			case (adrs[7:0])
				8'h00: mTimerEn = data[0];
				8'h01: mCount = data;
				8'h02: mCmp = data;
				8'h03: mMatch = mMatch & ~data[0];
				default: ;
			endcase
		end
	endfunction

	// Heartbeat source left out, callers keep alternate LED 0 off
	function automatic led_t ledExpect();
		return (mLed & ~mAlt) | (mAlt & {mDip[0], |mLevel, mMatch, 1'b0});
	endfunction

	// Listed registers, null blocks and unlisted offsets
	function automatic usiAdrs_t randomAdrs();
		int         kind;
		logic [4:0] pad;
		usiAdrs_t   adrs;
		kind = $unsigned($random(seed)) % 6;
		pad  = 5'($random(seed));
		case (kind)
			0: adrs = {lpGpioBlockId, pad, lpGpioLedCsr};
			1: adrs = {lpGpioBlockId, pad, lpGpioAltCsr};
			2: adrs = {lpTimerBlockId, pad, lpTimerCmpCsr};
			3: adrs = {3'(2 + $unsigned($random(seed)) % 6), pad, 8'($random(seed))};
			4: adrs = {lpGpioBlockId, pad, 8'(5 + $unsigned($random(seed)) % 251)};
			default: adrs = {lpTimerBlockId, pad, 8'(4 + $unsigned($random(seed)) % 252)};
		endcase
		return adrs;
	endfunction

	// ------------------------------
	// Bus driver and response monitor
	// ------------------------------
	// Called 1 ns after a rising edge, returns 1 ns after acceptance
	task automatic sendReq(input logic wr, input usiAdrs_t adrs, input usiData_t data);
		logic rdy;
		reqValid = 1'b1;
		reqWrite = wr;
		reqAdrs  = adrs;
		reqData  = data;
		do
		begin
			@(negedge iMCLK);
			rdy = reqReady;
			@(posedge iMCLK);
		end
		while (!rdy);
		#1;
		reqValid = 1'b0;
		reqWrite = 1'b0;
	endtask

	task automatic writeReg(input usiAdrs_t adrs, input usiData_t data);
		modelWrite(adrs, data);
		sendReq(1'b1, adrs, data);
	endtask

	task automatic readExpect(input usiAdrs_t adrs);
		expQ.push_back(predictRead(adrs));
		capQ.push_back(1'b0);
		sendReq(1'b0, adrs, '0);
	endtask

	task automatic readCapture(input usiAdrs_t adrs, output int acceptCycle);
		expQ.push_back('0);
		capQ.push_back(1'b1);
		sendReq(1'b0, adrs, '0);
		acceptCycle = cycleCnt;
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge iMCLK);
		#1;
	endtask

	task automatic drain();
		while (expQ.size() != 0)
			@(posedge iMCLK);
		#1;
	endtask

	// Random stalls on the response side
	always @(posedge iMCLK)
	begin
		#1;
		rspReady = stallEn ? (($random(seed) % 3) != 0) : 1'b1;
	end

	always @(negedge iMCLK)
	begin
		usiData_t expVal;
		bit       isCap;
		if (qnARST && rspValid && rspReady)
		begin
			if (expQ.size() == 0)
			begin
				$display("Response arrived with no read outstanding");
				stopOnError();
			end
			expVal = expQ.pop_front();
			isCap  = capQ.pop_front();
			if (isCap)
				capVal.push_back(rspData);
			else
				checkData(rspData, expVal, "read data");
		end
	end

	// ------------------------------
	// Tests
	// ------------------------------
	task automatic regTest(input int ops, input bit gaps);
		usiAdrs_t adrs;
		repeat (ops)
		begin
			adrs = randomAdrs();
			if (($random(seed) & 3) == 0)
				writeReg(adrs, $random(seed));
			else
				readExpect(adrs);
			if (gaps)
				idle($unsigned($random(seed)) % 4);
		end
		drain();
	endtask

	task automatic timerCountTest();
		int t1;
		int t2;
		writeReg(csrAddress(lpTimerBlockId, lpTimerCtrlCsr), 0);
		writeReg(csrAddress(lpTimerBlockId, lpTimerCountCsr), $random(seed));
		readExpect(csrAddress(lpTimerBlockId, lpTimerCountCsr));
		idle(5);
		readExpect(csrAddress(lpTimerBlockId, lpTimerCountCsr));
		drain();
		writeReg(csrAddress(lpTimerBlockId, lpTimerCtrlCsr), 1);
		repeat (3)
		begin
			idle($unsigned($random(seed)) % 8);
			capVal.delete();
			readCapture(csrAddress(lpTimerBlockId, lpTimerCountCsr), t1);
			idle($unsigned($random(seed)) % 8);
			readCapture(csrAddress(lpTimerBlockId, lpTimerCountCsr), t2);
			drain();
			checkData(capVal[1] - capVal[0], usiData_t'(t2 - t1), "timer tick difference");
		end
	endtask

	task automatic matchTest();
		usiData_t base;
		int       offset;
		base   = $random(seed);
		offset = 20 + $unsigned($random(seed)) % 40;
		writeReg(csrAddress(lpTimerBlockId, lpTimerCtrlCsr), 1);
		writeReg(csrAddress(lpGpioBlockId, lpGpioAltCsr), 32'h2);
		// Load, compare ahead, then clear any stale flag
		writeReg(csrAddress(lpTimerBlockId, lpTimerCountCsr), base);
		writeReg(csrAddress(lpTimerBlockId, lpTimerCmpCsr), base + offset);
		writeReg(csrAddress(lpTimerBlockId, lpTimerStatCsr), 1);
		readExpect(csrAddress(lpTimerBlockId, lpTimerStatCsr));
		drain();
		checkLed(led, ledExpect(), "LED 1 before match");
		idle(offset);
		mMatch = 1'b1;
		readExpect(csrAddress(lpTimerBlockId, lpTimerStatCsr));
		drain();
		checkLed(led, ledExpect(), "LED 1 after match");
		writeReg(csrAddress(lpTimerBlockId, lpTimerStatCsr), 1);
		readExpect(csrAddress(lpTimerBlockId, lpTimerStatCsr));
		drain();
		checkLed(led, ledExpect(), "LED 1 after clear");
	endtask

	task automatic switchTest(input int presses);
		int      idx;
		bit      isLong;
		pushSw_t bitMask;
		pushSw_t clr;
		writeReg(csrAddress(lpGpioBlockId, lpGpioAltCsr), 32'hC);
		repeat (presses)
		begin
			idx     = $unsigned($random(seed)) % 7;
			isLong  = ($random(seed) & 1) != 0;
			bitMask = pushSw_t'(1 << idx);
			mDip    = dipSw_t'($random(seed));
			dipSw   = mDip;
			pushSw  = bitMask;
			// Sync plus debounce plus margin
			idle(lpDebounce + 5);
			mLevel = bitMask;
			readExpect(csrAddress(lpGpioBlockId, lpGpioLevelCsr));
			checkLed(led, ledExpect(), "LED alternate while pressed");
			idle(isLong ? lpLong + 10 + $unsigned($random(seed)) % 8 : $unsigned($random(seed)) % 8);
			pushSw = '0;
			idle(lpDebounce + 5);
			mLevel = '0;
			mEdge  = mEdge | bitMask;
			if (isLong)
				mLong = mLong | bitMask;
			readExpect(csrAddress(lpGpioBlockId, lpGpioLevelCsr));
			readExpect(csrAddress(lpGpioBlockId, lpGpioEdgeCsr));
			readExpect(csrAddress(lpGpioBlockId, lpGpioLongCsr));
			if (($random(seed) & 1) != 0)
			begin
				clr = pushSw_t'($random(seed));
				writeReg(csrAddress(lpGpioBlockId, lpGpioEdgeCsr), usiData_t'(clr));
				writeReg(csrAddress(lpGpioBlockId, lpGpioLongCsr), usiData_t'(clr));
				readExpect(csrAddress(lpGpioBlockId, lpGpioEdgeCsr));
				readExpect(csrAddress(lpGpioBlockId, lpGpioLongCsr));
			end
			drain();
			checkLed(led, ledExpect(), "LED alternate after release");
		end
	endtask

	task automatic heartbeatTest();
		logic prev;
		bit   toggled;
		writeReg(csrAddress(lpGpioBlockId, lpGpioAltCsr), 32'h1);
		idle(2);
		prev    = led[0];
		toggled = 1'b0;
		repeat (3 * lpHbDiv)
		begin
			@(posedge iMCLK);
			#1;
			if (led[0] !== prev)
				toggled = 1'b1;
		end
		if (!toggled)
		begin
			$display("Heartbeat on LED 0 never toggled");
			stopOnError();
		end
		// Plain register drive
		writeReg(csrAddress(lpGpioBlockId, lpGpioAltCsr), 0);
		repeat (4)
		begin
			writeReg(csrAddress(lpGpioBlockId, lpGpioLedCsr), usiData_t'(led_t'($random(seed))));
			idle(2);
			checkLed(led, mLed, "LED register value");
		end
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial
	begin
		seed     = 95925;
		iMCLK    = 1'b0;
		qnARST   = 1'b0;
		reqValid = 1'b0;
		reqWrite = 1'b0;
		reqAdrs  = '0;
		reqData  = '0;
		rspReady = 1'b0;
		stallEn  = 1'b0;
		pushSw   = '0;
		mDip     = dipSw_t'($random(seed));
		dipSw    = mDip;
		{mLed, mAlt, mLevel, mEdge, mLong} = '0;
		{mTimerEn, mMatch, mCmp, mCount}   = '0;
		repeat (5) @(posedge iMCLK);
		#1;
		qnARST = 1'b1;
		idle(1);
		if (!reqReady || rspValid)
		begin
			$display("Bus handshake not idle after reset");
			stopOnError();
		end
		regTest(150, 1'b1);
		stallEn = 1'b1;
		regTest(200, 1'b0);
		stallEn = 1'b0;
		timerCountTest();
		repeat (2)
			matchTest();
		switchTest(24);
		heartbeatTest();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- build.f
MidiCtrlPkg.sv
SwitchConditioner.sv
GpioBlock.sv
SysTimerBlock.sv
UsiBus.sv
MidiCtrlTop.sv
MidiCtrlTb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing --top-module MidiCtrlTb -f build.f -o MidiCtrlSim || exit 1
out=$(./obj_dir/MidiCtrlSim 2>&1)
echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
